// ==== design/vcu_pkg.sv ====
// class indices, instruction field positions, vtype codes, decode enums and vlmax function
`default_nettype none

package vcu_pkg;

   localparam int INSTR_CLASS_W = 12; // one-hot class bus, bits 1..0 unused

   localparam int CLS_IDX_STORE = 2;
   localparam int CLS_STORE     = 3;
   localparam int CLS_IDX_LOAD  = 4;
   localparam int CLS_LOAD      = 5;
   localparam int CLS_OPMVV     = 6;
   localparam int CLS_OPMVX     = 7;
   localparam int CLS_OPIVV     = 8;
   localparam int CLS_OPIVI     = 9;
   localparam int CLS_OPIVX     = 10;
   localparam int CLS_CONFIG    = 11;

   // instruction word fields
   localparam int FUNCT6_HI = 31;
   localparam int FUNCT6_LO = 26;
   localparam int VM_BIT    = 25;
   localparam int VS2_HI    = 24;
   localparam int VS2_LO    = 20;
   localparam int VS1_HI    = 19; // also the 5-bit immediate
   localparam int VS1_LO    = 15;
   localparam int VD_HI     = 11;
   localparam int VD_LO     = 7;

   localparam int         VSETVL_HI   = 31;
   localparam int         VSETVL_LO   = 30;
   localparam logic [1:0] VSETVL_MARK = 2'b10; // vsetvl, vtype from rs2
   localparam int VSETVLI_SEW_HI  = 24;
   localparam int VSETVLI_SEW_LO  = 22;
   localparam int VSETVLI_LMUL_HI = 21;
   localparam int VSETVLI_LMUL_LO = 20;
   localparam int LMUL_EXT_BIT    = 25; // msb of lmul code in vsetvli

   // vtype layout in rs2 for vsetvl
   localparam int VTYPE_SEW_HI  = 5;
   localparam int VTYPE_SEW_LO  = 3;
   localparam int VTYPE_LMUL_HI = 2;
   localparam int VTYPE_LMUL_LO = 0;

   typedef logic [2:0] sew_t;  // 0/1/2 -> 8/16/32 bit
   typedef logic [2:0] lmul_t; // 0..3 -> x1..x8, 5..7 -> /8../2

   typedef enum logic [2:0] {
      IT_NORMAL    = 3'd0,
      IT_STORE     = 3'd2,
      IT_IDX_STORE = 3'd3,
      IT_LOAD      = 3'd4,
      IT_IDX_LOAD  = 3'd5,
      IT_CONFIG    = 3'd6,
      IT_NONE      = 3'd7
   } inst_type_e;

   typedef enum logic [1:0] {OP2_VV, OP2_VX, OP2_VI, OP2_NONE} op2_sel_e;

   typedef enum logic [3:0] {
      ALU_NOP, ALU_ADD, ALU_SUB,
      ALU_AND, ALU_OR, ALU_XOR,
      ALU_SEQ, ALU_SNE,
      ALU_SLL, ALU_SRL, ALU_SRA,
      ALU_MUL, ALU_MULH
   } alu_op_e;

   // elements per register group for a given sew and lmul
   function automatic logic [31:0] vlmax_of(input int unsigned vlen, input sew_t sew,
                                            input lmul_t lmul);
      logic [31:0] elems;
      elems = 32'(vlen / 8) >> sew; // bytes / element bytes
      case (lmul)
         3'd0, 3'd1, 3'd2, 3'd3: return elems << lmul[1:0];
         3'd4:                   return '0; // reserved
         default:                return elems >> (4'd8 - {1'b0, lmul}); // fractional
      endcase
   endfunction

endpackage

`default_nettype wire

// ==== design/issue_if.sv ====
// issue_if interface carrying the captured instruction and the ready level
`timescale 1ns/1ps
`default_nettype none

interface issue_if import vcu_pkg::*; ();

   logic [INSTR_CLASS_W-1:0] cls;   // one-hot class, zero = empty slot
   logic [31:0]              instr; // captured instruction word
   logic [31:0]              rs1;   // scalar operand 1
   logic [31:0]              rs2;   // scalar operand 2, vtype for vsetvl
   logic                     rdy;   // capture may load next edge

   // capture register side
   modport cap (output cls, output instr, output rs1, output rs2, input rdy);

   // decode and config side, read only
   modport use_side (input cls, input instr, input rs1, input rs2);

   // dispatch side also owns the ready level
   modport use_rdy (input cls, input instr, input rs1, input rs2, output rdy);

endinterface

`default_nettype wire

// ==== design/instr_capture.sv ====
// instr_capture module, input register stage that holds while the unit is stalled
`timescale 1ns/1ps
`default_nettype none

module instr_capture import vcu_pkg::*; (
   input  logic                     clk,
   input  logic                     rstn,
   input  logic [INSTR_CLASS_W-1:0] instr_vld_i,    // one-hot class, zero when idle
   input  logic [31:0]              vector_instr_i,
   input  logic [31:0]              scalar_rs1_i,
   input  logic [31:0]              scalar_rs2_i,
   issue_if.cap                     issue
);

   logic load_en;

   assign load_en = issue.rdy; // ready level from dispatch, no loop through inputs

   // class register, empty after reset
   always_ff @(posedge clk)
   begin
      if (!rstn)
         issue.cls <= '0;
      else if (load_en)
         issue.cls <= instr_vld_i; // all-zero class loads as empty slot
   end

   // payload only matters while cls is nonzero
   always_ff @(posedge clk)
   begin
      if (load_en)
      begin
         issue.instr <= vector_instr_i;
         issue.rs1   <= scalar_rs1_i;
         issue.rs2   <= scalar_rs2_i;
      end
   end

endmodule

`default_nettype wire

// ==== design/vtype_config.sv ====
// vtype_config module, sew/lmul/vl registers updated by vsetvl and vsetvli
`timescale 1ns/1ps
`default_nettype none

module vtype_config import vcu_pkg::*; #(
   parameter int VLEN = 4096
) (
   input  logic        clk,
   input  logic        rstn,
   issue_if.use_side   issue,
   output sew_t        sew_o,
   output lmul_t       lmul_o,
   output logic [31:0] vl_o
);

   logic        is_config;
   logic        is_vsetvl;
   sew_t        sew_nxt;
   lmul_t       lmul_nxt;
   logic [31:0] vlmax;
   logic [31:0] vl_nxt;
   logic [4:0]  vs1_fld;
   logic [4:0]  vd_fld;

   assign is_config = issue.cls[CLS_CONFIG];
   assign is_vsetvl = issue.instr[VSETVL_HI:VSETVL_LO] == VSETVL_MARK;
   assign vs1_fld   = issue.instr[VS1_HI:VS1_LO]; // rs1 index, avl source
   assign vd_fld    = issue.instr[VD_HI:VD_LO];   // rd index

   // next vtype, rs2 for vsetvl else the immediate fields
   always_comb
   begin
      if (is_vsetvl)
      begin
         sew_nxt  = issue.rs2[VTYPE_SEW_HI:VTYPE_SEW_LO];
         lmul_nxt = issue.rs2[VTYPE_LMUL_HI:VTYPE_LMUL_LO];
      end
      else
      begin
         sew_nxt  = issue.instr[VSETVLI_SEW_HI:VSETVLI_SEW_LO];
         lmul_nxt = {issue.instr[LMUL_EXT_BIT], issue.instr[VSETVLI_LMUL_HI:VSETVLI_LMUL_LO]};
      end
   end

   assign vlmax = vlmax_of(VLEN, sew_nxt, lmul_nxt); // from the new vtype

   // avl from rs1, else vlmax when rd set, else keep
   assign vl_nxt = (vs1_fld != '0) ? issue.rs1 :
                   (vd_fld != '0)  ? vlmax     : vl_o;

   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         sew_o  <= sew_t'(3'd2); // 32-bit elements
         lmul_o <= '0;           // x1
         vl_o   <= 32'(VLEN / 32);
      end
      else if (is_config) // config never stalls, one update per instruction
      begin
         sew_o  <= sew_nxt;
         lmul_o <= lmul_nxt;
         vl_o   <= vl_nxt;
      end
   end

endmodule

`default_nettype wire

// ==== design/instr_decode.sv ====
// instr_decode module, instruction type, operand select, alu opcode and operand decode
`timescale 1ns/1ps
`default_nettype none

module instr_decode import vcu_pkg::*; (
   issue_if.use_side   issue,
   output inst_type_e  inst_type_o,
   output op2_sel_e    op2_sel_o,
   output alu_op_e     alu_opmode_o,
   output logic [31:0] alu_x_data_o,
   output logic [4:0]  alu_imm_o,
   output logic        vector_mask_o
);

   logic [5:0] funct6;
   logic       opi_cls;
   logic       opm_cls;

   assign funct6  = issue.instr[FUNCT6_HI:FUNCT6_LO];
   assign opi_cls = issue.cls[CLS_OPIVV] | issue.cls[CLS_OPIVI] | issue.cls[CLS_OPIVX];
   assign opm_cls = issue.cls[CLS_OPMVV] | issue.cls[CLS_OPMVX];

   // memory classes win over arithmetic
   always_comb
   begin
      if (issue.cls[CLS_STORE])          inst_type_o = IT_STORE;
      else if (issue.cls[CLS_IDX_STORE]) inst_type_o = IT_IDX_STORE;
      else if (issue.cls[CLS_LOAD])      inst_type_o = IT_LOAD;
      else if (issue.cls[CLS_IDX_LOAD])  inst_type_o = IT_IDX_LOAD;
      else if (issue.cls[CLS_CONFIG])    inst_type_o = IT_CONFIG;
      else if (opi_cls || opm_cls)       inst_type_o = IT_NORMAL;
      else                               inst_type_o = IT_NONE; // empty slot
   end

   // second operand source
   always_comb
   begin
      if (issue.cls[CLS_OPIVV] || issue.cls[CLS_OPMVV])      op2_sel_o = OP2_VV;
      else if (issue.cls[CLS_OPIVX] || issue.cls[CLS_OPMVX]) op2_sel_o = OP2_VX;
      else if (issue.cls[CLS_OPIVI])                         op2_sel_o = OP2_VI;
      else                                                   op2_sel_o = OP2_NONE;
   end

   // funct6 maps differ between opi and opm spaces
   always_comb
   begin
      alu_opmode_o = ALU_NOP;
      if (opi_cls)
      begin
         case (funct6)
            6'b000000: alu_opmode_o = ALU_ADD;
            6'b000010: alu_opmode_o = ALU_SUB;
            6'b001001: alu_opmode_o = ALU_AND;
            6'b001010: alu_opmode_o = ALU_OR;
            6'b001011: alu_opmode_o = ALU_XOR;
            6'b011000: alu_opmode_o = ALU_SEQ; // vmseq
            6'b011001: alu_opmode_o = ALU_SNE; // vmsne
            6'b100101: alu_opmode_o = ALU_SLL;
            6'b101000: alu_opmode_o = ALU_SRL;
            6'b101001: alu_opmode_o = ALU_SRA;
            default:   alu_opmode_o = ALU_NOP;
         endcase
      end
      else if (opm_cls)
      begin
         case (funct6)
            6'b000000: alu_opmode_o = ALU_ADD;  // redsum
            6'b000001: alu_opmode_o = ALU_AND;
            6'b000010: alu_opmode_o = ALU_OR;
            6'b000011: alu_opmode_o = ALU_XOR;
            6'b100101: alu_opmode_o = ALU_MUL;
            6'b100111: alu_opmode_o = ALU_MULH;
            default:   alu_opmode_o = ALU_NOP;
         endcase
      end
   end

   assign alu_x_data_o  = issue.rs1;
   assign alu_imm_o     = issue.instr[VS1_HI:VS1_LO]; // simm5 shares vs1 field
   assign vector_mask_o = ~issue.instr[VM_BIT];       // vm=0 means masked

endmodule

`default_nettype wire

// ==== design/port_dispatch.sv ====
// port_dispatch module, vd scoreboard, lowest ready port grant, start pulses and ready level
`timescale 1ns/1ps
`default_nettype none

module port_dispatch import vcu_pkg::*; #(
   parameter int W_PORTS_NUM     = 4,
   parameter int DEP_HOLD_CYCLES = 11
) (
   input  logic                   clk,
   input  logic                   rstn,
   issue_if.use_rdy               issue,
   input  logic [W_PORTS_NUM-1:0] port_group_ready_i,
   output logic [W_PORTS_NUM-1:0] start_o
);

   localparam int CNT_W = $clog2(DEP_HOLD_CYCLES + 1);

   logic [W_PORTS_NUM-1:0]            sb_vld; // entry in flight
   logic [W_PORTS_NUM-1:0][4:0]       sb_vd;  // its destination
   logic [W_PORTS_NUM-1:0][CNT_W-1:0] sb_cnt; // edges left
   logic [W_PORTS_NUM-1:0]            hit;
   logic [W_PORTS_NUM-1:0]            lowest_rdy;
   logic [4:0] vs1_fld;
   logic [4:0] vs2_fld;
   logic [4:0] vd_fld;
   logic       slot_empty;
   logic       is_config;
   logic       needs_port;
   logic       hazard;

   assign vs1_fld = issue.instr[VS1_HI:VS1_LO];
   assign vs2_fld = issue.instr[VS2_HI:VS2_LO];
   assign vd_fld  = issue.instr[VD_HI:VD_LO];

   assign slot_empty = ~|issue.cls[INSTR_CLASS_W-1:CLS_IDX_STORE]; // bits 1..0 ignored
   assign is_config  = issue.cls[CLS_CONFIG];
   assign needs_port = !slot_empty && !is_config;

   // read-after-write check against every live entry
   always_comb
   begin
      for (int i = 0; i < W_PORTS_NUM; i++)
         hit[i] = sb_vld[i] && (sb_vd[i] == vs1_fld || sb_vd[i] == vs2_fld);
   end

   assign hazard     = needs_port && (|hit);
   assign lowest_rdy = port_group_ready_i & (~port_group_ready_i + 1'b1); // lowest set bit

   assign start_o   = (needs_port && !hazard) ? lowest_rdy : '0;
   assign issue.rdy = slot_empty || is_config || (|start_o); // start implies accept

   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         sb_vld <= '0;
         sb_cnt <= '0;
      end
      else
      begin
         for (int i = 0; i < W_PORTS_NUM; i++)
         begin
            if (start_o[i])
            begin
               sb_vld[i] <= 1'b1;
               sb_cnt[i] <= CNT_W'(DEP_HOLD_CYCLES - 1); // valid for hold edges
            end
            else if (sb_vld[i])
            begin
               if (sb_cnt[i] == '0)
                  sb_vld[i] <= 1'b0; // hold expired
               else
                  sb_cnt[i] <= sb_cnt[i] - 1'b1;
            end
         end
      end
   end

   // vd only read while its valid flag is set
   always_ff @(posedge clk)
   begin
      for (int i = 0; i < W_PORTS_NUM; i++)
         if (start_o[i])
            sb_vd[i] <= vd_fld;
   end

endmodule

`default_nettype wire

// ==== design/v_cu_top.sv ====
// v_cu_top module, vector control unit top with capture, config, decode and dispatch
`timescale 1ns/1ps
`default_nettype none

module v_cu_top import vcu_pkg::*; #(
   parameter int VLEN            = 4096,
   parameter int W_PORTS_NUM     = 4,
   parameter int DEP_HOLD_CYCLES = 11
) (
   input  logic                     clk,
   input  logic                     rstn,
   input  logic [INSTR_CLASS_W-1:0] instr_vld_i,
   input  logic [31:0]              vector_instr_i,
   input  logic [31:0]              scalar_rs1_i,
   input  logic [31:0]              scalar_rs2_i,
   input  logic [W_PORTS_NUM-1:0]   port_group_ready_i,
   output logic                     instr_rdy_o,  // level, upstream holds while low
   output sew_t                     sew_o,
   output lmul_t                    lmul_o,
   output logic [31:0]              vl_o,
   output inst_type_e               inst_type_o,
   output op2_sel_e                 op2_sel_o,
   output alu_op_e                  alu_opmode_o,
   output logic [31:0]              alu_x_data_o,
   output logic [4:0]               alu_imm_o,
   output logic                     vector_mask_o,
   output logic [W_PORTS_NUM-1:0]   start_o       // one-hot pulse per instruction
);

   issue_if issue ();

   instr_capture u_capture (
      .clk            (clk),
      .rstn           (rstn),
      .instr_vld_i    (instr_vld_i),
      .vector_instr_i (vector_instr_i),
      .scalar_rs1_i   (scalar_rs1_i),
      .scalar_rs2_i   (scalar_rs2_i),
      .issue          (issue)
   );

   vtype_config #(.VLEN(VLEN)) u_config (
      .clk    (clk),
      .rstn   (rstn),
      .issue  (issue),
      .sew_o  (sew_o),
      .lmul_o (lmul_o),
      .vl_o   (vl_o)
   );

   instr_decode u_decode (
      .issue         (issue),
      .inst_type_o   (inst_type_o),
      .op2_sel_o     (op2_sel_o),
      .alu_opmode_o  (alu_opmode_o),
      .alu_x_data_o  (alu_x_data_o),
      .alu_imm_o     (alu_imm_o),
      .vector_mask_o (vector_mask_o)
   );

   port_dispatch #(
      .W_PORTS_NUM     (W_PORTS_NUM),
      .DEP_HOLD_CYCLES (DEP_HOLD_CYCLES)
   ) u_dispatch (
      .clk                (clk),
      .rstn               (rstn),
      .issue              (issue),
      .port_group_ready_i (port_group_ready_i),
      .start_o            (start_o)
   );

   assign instr_rdy_o = issue.rdy;

endmodule

`default_nettype wire

// ==== test/v_cu_checker.sv ====
// v_cu_checker module with start, ready and reset assertions, bound to v_cu_top
`timescale 1ns/1ps
`default_nettype none

module v_cu_checker import vcu_pkg::*; #(
   parameter int W_PORTS_NUM = 4
) (
   input logic                   clk,
   input logic                   rstn,
   input logic                   instr_rdy_o,
   input logic [W_PORTS_NUM-1:0] start_o,
   input logic [W_PORTS_NUM-1:0] port_group_ready_i,
   input sew_t                   sew_o
);

   // at most one port per instruction
   a_start_onehot: assert property (@(posedge clk) disable iff (!rstn) $onehot0(start_o))
      else $error("start_o has more than one bit set");

   // never start a busy port
   a_start_ready: assert property (@(posedge clk) disable iff (!rstn)
      (start_o & ~port_group_ready_i) == '0)
      else $error("start_o hits a port that is not ready");

   a_start_rdy: assert property (@(posedge clk) disable iff (!rstn) (|start_o) |-> instr_rdy_o)
      else $error("start_o raised while instr_rdy_o is low");

   // 32-bit elements right after reset
   a_reset_sew: assert property (@(posedge clk) $rose(rstn) |=> (sew_o == 3'd2))
      else $error("sew_o is not 32-bit after reset release");

endmodule

bind v_cu_top v_cu_checker #(.W_PORTS_NUM(W_PORTS_NUM)) u_checker (
   .clk                (clk),
   .rstn               (rstn),
   .instr_rdy_o        (instr_rdy_o),
   .start_o            (start_o),
   .port_group_ready_i (port_group_ready_i),
   .sew_o              (sew_o)
);

`default_nettype wire

// ==== test/tb_v_cu.sv ====
// tb_v_cu testbench with directed reset, config, decode, allocation and dependency tests
`timescale 1ns/1ps
`default_nettype none

module tb_v_cu import vcu_pkg::*; ();

   localparam int VLEN   = 4096;
   localparam int PORTS  = 4;
   localparam int HOLD   = 11;
   localparam int PERIOD = 40;
   // reset, config, decode, allocation, dependency, margin
   localparam int BUDGET = 10 + 40 + 400 + 40 + (3 * HOLD + 20) + 100;

   // class bit positions of the one-hot bus
   localparam int IDX_STORE_BIT = 2;
   localparam int STORE_BIT     = 3;
   localparam int IDX_LOAD_BIT  = 4;
   localparam int LOAD_BIT      = 5;
   localparam int OPMVV_BIT     = 6;
   localparam int OPMVX_BIT     = 7;
   localparam int OPIVV_BIT     = 8;
   localparam int OPIVI_BIT     = 9;
   localparam int OPIVX_BIT     = 10;
   localparam int CONFIG_BIT    = 11;

   logic             clk;
   logic             rstn;
   logic [11:0]      instr_vld_i;
   logic [31:0]      vector_instr_i;
   logic [31:0]      scalar_rs1_i;
   logic [31:0]      scalar_rs2_i;
   logic [PORTS-1:0] port_group_ready_i;
   logic             instr_rdy_o;
   sew_t             sew_o;
   lmul_t            lmul_o;
   logic [31:0]      vl_o;
   inst_type_e       inst_type_o;
   op2_sel_e         op2_sel_o;
   alu_op_e          alu_opmode_o;
   logic [31:0]      alu_x_data_o;
   logic [4:0]       alu_imm_o;
   logic             vector_mask_o;
   logic [PORTS-1:0] start_o;

   int          value_errs;
   int          proto_errs; // handshake and stall failures
   logic [31:0] rng;
   logic [31:0] model_vl;   // vl the unit should hold now

   v_cu_top #(.VLEN(VLEN), .W_PORTS_NUM(PORTS), .DEP_HOLD_CYCLES(HOLD)) DUT (.*);

   initial
   begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   initial
   begin
      #(BUDGET * PERIOD);
      $display("timeout, tests did not finish within %0d cycles", BUDGET);
      $display("ERRORS FOUND");
      $finish;
   end

   task automatic check_type(input string name, input inst_type_e got, input inst_type_e exp);
      if (got !== exp)
      begin
         value_errs++;
         $display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic check_op2(input string name, input op2_sel_e got, input op2_sel_e exp);
      if (got !== exp)
      begin
         value_errs++;
         $display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic check_alu(input string name, input alu_op_e got, input alu_op_e exp);
      if (got !== exp)
      begin
         value_errs++;
         $display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic check_sew(input string name, input sew_t got, input sew_t exp); // lmul too
      if (got !== exp)
      begin
         value_errs++;
         $display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
      begin
         value_errs++;
         $display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x ^= x << 13;
      x ^= x >> 17;
      x ^= x << 5;
      return x;
   endfunction

   // opcode 1010111, funct3 zero
   function automatic logic [31:0] arith_word(input logic [5:0] f6, input logic vm,
                                              input logic [4:0] vs2, input logic [4:0] vs1,
                                              input logic [4:0] vd);
      return {f6, vm, vs2, vs1, 3'b000, vd, 7'h57};
   endfunction

   function automatic logic [31:0] vsetvli_word(input sew_t sew, input lmul_t lmul,
                                                input logic [4:0] vs1, input logic [4:0] vd);
      return {6'b0, lmul[2], sew, lmul[1:0], vs1, 3'b111, vd, 7'h57};
   endfunction

   function automatic logic [31:0] vsetvl_word(input logic [4:0] vs1, input logic [4:0] vd);
      return {2'b10, 10'b0, vs1, 3'b111, vd, 7'h57}; // bits 31..30 = 10
   endfunction

   // 512 bytes over element size, scaled by lmul
   function automatic logic [31:0] exp_vlmax(input sew_t sew, input lmul_t lmul);
      int unsigned elems;
      elems = (VLEN / 8) / (1 << sew);
      case (lmul)
         3'd0, 3'd1, 3'd2, 3'd3: return elems * (1 << lmul);
         3'd5:    return elems / 8;
         3'd6:    return elems / 4;
         3'd7:    return elems / 2;
         default: return 0;
      endcase
   endfunction

   function automatic alu_op_e exp_alu(input logic opm, input logic [5:0] f6);
      alu_op_e op;
      op = ALU_NOP;
      if (opm)
         case (f6)
            6'h00: op = ALU_ADD;
            6'h01: op = ALU_AND;
            6'h02: op = ALU_OR;
            6'h03: op = ALU_XOR;
            6'h25: op = ALU_MUL;
            6'h27: op = ALU_MULH;
            default: ;
         endcase
      else
         case (f6)
            6'h00: op = ALU_ADD;
            6'h02: op = ALU_SUB;
            6'h09: op = ALU_AND;
            6'h0a: op = ALU_OR;
            6'h0b: op = ALU_XOR;
            6'h18: op = ALU_SEQ;
            6'h19: op = ALU_SNE;
            6'h25: op = ALU_SLL;
            6'h28: op = ALU_SRL;
            6'h29: op = ALU_SRA;
            default: ;
         endcase
      return op;
   endfunction

   function automatic op2_sel_e exp_op2(input int b);
      if (b == OPIVV_BIT || b == OPMVV_BIT) return OP2_VV;
      if (b == OPIVX_BIT || b == OPMVX_BIT) return OP2_VX;
      if (b == OPIVI_BIT) return OP2_VI;
      return OP2_NONE;
   endfunction

   function automatic inst_type_e exp_type(input int b);
      case (b)
         STORE_BIT:     return IT_STORE;
         IDX_STORE_BIT: return IT_IDX_STORE;
         LOAD_BIT:      return IT_LOAD;
         IDX_LOAD_BIT:  return IT_IDX_LOAD;
         CONFIG_BIT:    return IT_CONFIG;
         default:       return IT_NORMAL;
      endcase
   endfunction

   task automatic drive_idle();
      instr_vld_i    = '0;
      vector_instr_i = '0;
      scalar_rs1_i   = '0;
      scalar_rs2_i   = '0;
   endtask

   // present one instruction, hold until an edge with ready high, then go idle
   task automatic send_instr(input int cls_bit, input logic [31:0] instr,
                             input logic [31:0] rs1, input logic [31:0] rs2);
      int waited;
      waited = 0;
      @(posedge clk);
      #2;
      instr_vld_i          = '0;
      instr_vld_i[cls_bit] = 1'b1;
      vector_instr_i       = instr;
      scalar_rs1_i         = rs1;
      scalar_rs2_i         = rs2;
      @(negedge clk);
      while (!instr_rdy_o && waited < 4 * HOLD)
      begin
         waited++;
         @(negedge clk);
      end
      if (!instr_rdy_o)
      begin
         proto_errs++;
         $display("instruction was never accepted, instr_rdy_o stayed low at %0t", $time);
      end
      @(posedge clk); // accept edge
      #2 drive_idle();
   endtask

   task automatic reset_values();
      @(negedge clk);
      check_word("instr_rdy_o", 32'(instr_rdy_o), 32'd1);
      check_word("start_o", 32'(start_o), 32'd0);
      check_sew("sew_o", sew_o, 3'd2);
      check_sew("lmul_o", lmul_o, 3'd0);
      check_word("vl_o", vl_o, 32'(VLEN / 32));
   endtask

   // vl still old in the capture cycle, new one edge later
   task automatic apply_config(input logic [31:0] instr, input logic [31:0] rs1,
                               input logic [31:0] rs2, input sew_t sew, input lmul_t lmul,
                               input logic [31:0] vl);
      send_instr(CONFIG_BIT, instr, rs1, rs2);
      @(negedge clk);
      check_type("inst_type_o", inst_type_o, IT_CONFIG);
      check_word("start_o", 32'(start_o), 32'd0); // config never starts
      check_word("vl_o", vl_o, model_vl);
      @(negedge clk);
      check_sew("sew_o", sew_o, sew);
      check_sew("lmul_o", lmul_o, lmul);
      check_word("vl_o", vl_o, vl);
      model_vl = vl;
   endtask

   task automatic config_updates();
      apply_config(vsetvli_word(3'd0, 3'd1, 5'd0, 5'd1), 0, 0, 3'd0, 3'd1, exp_vlmax(0, 1));
      apply_config(vsetvli_word(3'd2, 3'd0, 5'd3, 5'd1), 32'd37, 0, 3'd2, 3'd0, 32'd37);
      // vsetvl, vtype {sew, lmul} in rs2
      apply_config(vsetvl_word(5'd0, 5'd2), 0, {26'b0, 3'd1, 3'd7}, 3'd1, 3'd7,
                   exp_vlmax(1, 7));
      apply_config(vsetvli_word(3'd0, 3'd3, 5'd0, 5'd0), 0, 0, 3'd0, 3'd3, model_vl); // keep vl
   endtask

   // vd 31 never matches the vs fields below, so no stall
   task automatic decode_one(input int cls_bit, input logic [5:0] f6, input logic vm,
                             input logic [4:0] vs2, input logic [4:0] vs1,
                             input logic [31:0] rs1);
      logic opm;
      opm = (cls_bit == OPMVV_BIT) || (cls_bit == OPMVX_BIT);
      send_instr(cls_bit, arith_word(f6, vm, vs2, vs1, 5'd31), rs1, 32'h0);
      @(negedge clk);
      check_type("inst_type_o", inst_type_o, exp_type(cls_bit));
      check_op2("op2_sel_o", op2_sel_o, exp_op2(cls_bit));
      check_alu("alu_opmode_o", alu_opmode_o, (cls_bit >= OPMVV_BIT) ? exp_alu(opm, f6) : ALU_NOP);
      check_word("alu_x_data_o", alu_x_data_o, rs1);
      check_word("alu_imm_o", 32'(alu_imm_o), 32'(vs1));
      check_word("vector_mask_o", 32'(vector_mask_o), 32'(!vm));
   endtask

   task automatic decode_classes();
      logic [5:0] codes [0:13];
      int         classes [0:4];
      int         mem [0:3];
      logic [5:0] f6;
      codes   = '{6'h00, 6'h01, 6'h02, 6'h03, 6'h09, 6'h0a, 6'h0b,
                  6'h18, 6'h19, 6'h25, 6'h27, 6'h28, 6'h29, 6'h3f};
      classes = '{OPIVV_BIT, OPIVI_BIT, OPIVX_BIT, OPMVV_BIT, OPMVX_BIT};
      mem     = '{STORE_BIT, IDX_STORE_BIT, LOAD_BIT, IDX_LOAD_BIT};
      foreach (classes[c])
         foreach (codes[k])
            decode_one(classes[c], codes[k], k[0], 5'(k), 5'(k + c + 1), 32'h1000 * k + c);
      for (int n = 0; n < 24; n++)
      begin
         rng = xorshift(rng);
         f6  = rng[20] ? codes[rng[24:21] % 14] : rng[5:0]; // mix table hits and misses
         decode_one(classes[rng[8:6] % 5], f6, rng[9], 5'(rng[14:10] % 31),
                    5'(rng[19:15] % 31), xorshift(rng));
      end
      foreach (mem[m])
         decode_one(mem[m], 6'h00, 1'b1, 5'd1, 5'd2, 32'h0); // memory, no alu op
   endtask

   task automatic port_allocation();
      @(posedge clk);
      #2 port_group_ready_i = 4'b0110;
      send_instr(OPIVV_BIT, arith_word(6'h00, 1'b1, 5'd1, 5'd2, 5'd3), 0, 0);
      @(negedge clk);
      check_word("start_o", 32'(start_o), 32'b0010); // lowest ready port
      check_word("instr_rdy_o", 32'(instr_rdy_o), 32'd1);
      @(posedge clk);
      #2 port_group_ready_i = '0;
      send_instr(OPIVX_BIT, arith_word(6'h02, 1'b1, 5'd4, 5'd6, 5'd7), 0, 0);
      repeat (6)
      begin
         @(negedge clk);
         check_word("instr_rdy_o", 32'(instr_rdy_o), 32'd0);
         check_word("start_o", 32'(start_o), 32'd0);
      end
      @(posedge clk);
      #2 port_group_ready_i = 4'b1100;
      @(negedge clk);
      check_word("start_o", 32'(start_o), 32'b0100);
      check_word("instr_rdy_o", 32'(instr_rdy_o), 32'd1);
      @(posedge clk);
      #2 port_group_ready_i = '1;
   endtask

   task automatic dependency_stall();
      int stalls;
      stalls = 0;
      repeat (HOLD + 2) @(posedge clk); // let old entries expire
      send_instr(OPIVV_BIT, arith_word(6'h00, 1'b1, 5'd1, 5'd2, 5'd5), 0, 0);
      @(negedge clk);
      check_word("start_o", 32'(start_o), 32'b0001);
      // reads vs2 = 5 while entry 0 holds vd 5
      send_instr(OPIVV_BIT, arith_word(6'h00, 1'b1, 5'd5, 5'd1, 5'd6), 0, 0);
      @(negedge clk);
      while (start_o == '0 && stalls < 3 * HOLD)
      begin
         check_word("instr_rdy_o", 32'(instr_rdy_o), 32'd0);
         stalls++;
         @(negedge clk);
      end
      check_word("start_o", 32'(start_o), 32'b0001);
      // entry was set one edge before the reader was captured
      check_word("hold edges", 32'(stalls + 1), 32'(HOLD));
      send_instr(OPIVV_BIT, arith_word(6'h00, 1'b1, 5'd7, 5'd8, 5'd9), 0, 0);
      @(negedge clk);
      check_word("start_o", 32'(start_o), 32'b0001); // no match, starts at once
   endtask

   initial
   begin
      value_errs         = 0;
      proto_errs         = 0;
      rng                = 32'd38939;
      model_vl           = 32'(VLEN / 32); // reset vl
      rstn               = 1'b0;
      port_group_ready_i = '1;
      drive_idle();
      repeat (4) @(posedge clk);
      #2 rstn = 1'b1;
      reset_values();
      config_updates();
      decode_classes();
      port_allocation();
      dependency_stall();
      @(posedge clk);
      $display("value errors %0d, handshake errors %0d", value_errs, proto_errs);
      if (value_errs + proto_errs == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

endmodule

`default_nettype wire

// ==== src.f ====
design/vcu_pkg.sv
design/issue_if.sv
design/instr_capture.sv
design/vtype_config.sv
design/instr_decode.sv
design/port_dispatch.sv
design/v_cu_top.sv
test/v_cu_checker.sv
test/tb_v_cu.sv

// ==== run.sh ====
#!/bin/sh
# build with verilator, run, then look for the pass line in the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module tb_v_cu -f src.f \
   --Mdir obj_dir -o sim_v_cu
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/sim_v_cu > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qx "NO ERRORS" "$LOG"; then
   echo "simulation passed"
   exit 0
fi
echo "simulation failed, see $LOG"
exit 1
